// ==== Bender.yml ====
package:
  name: frontend

sources:
  - files:
      - design/frontend_pkg.sv
      - design/fetch_if.sv
      - design/inst_mem.sv
      - design/fetch_unit.sv
      - design/inst_buffer.sv
      - design/predecode.sv
      - design/frontend_top.sv

  - target: simulation
    files:
      - tb/frontend_tb.sv

// ==== design/fetch_if.sv ====
`timescale 1ns/100ps

interface fetch_if #(
    parameter int N = frontend_pkg::default_n
) ();
    import frontend_pkg::*;

    localparam int cnt_w = $clog2(N + 1);

    fetch_packet_t [N-1:0] packets;  // Oldest in slot 0
    logic [cnt_w-1:0]      count;    // Valid packets this cycle
    logic [cnt_w-1:0]      spots;    // Free entries the buffer will accept
    logic                  restore;  // Branch stack recovery

    // Fetch may never send more than spots
    modport fetch_side (
        output packets,
        output count,
        input  spots,
        input  restore
    );

    modport buffer_side (
        input  packets,
        input  count,
        output spots,
        input  restore
    );
endinterface

// ==== design/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit #(
    parameter int N          = frontend_pkg::default_n,
    parameter int IMEM_WORDS = frontend_pkg::default_imem_words
) (
    input  logic                                 clock,
    input  logic                                 rst,
    input  logic                                 fetch_enable,
    input  logic [frontend_pkg::xlen-1:0]        restore_pc,
    fetch_if.fetch_side                          fetch,
    output logic [$clog2(IMEM_WORDS)-1:0]        raddr,
    input  logic [N-1:0][frontend_pkg::xlen-1:0] rdata
);
    import frontend_pkg::*;

    localparam int cnt_w  = $clog2(N + 1);
    localparam int addr_w = $clog2(IMEM_WORDS);

    // PC space covered by the memory
    localparam logic [xlen-1:0] mem_bytes = xlen'(IMEM_WORDS * 4);

    logic [xlen-1:0]  pc;
    logic [xlen-1:0]  next_pc;
    logic [cnt_w-1:0] send;   // Packets offered this cycle

    // Word index of the first instruction at the current PC
    assign raddr = addr_w'((pc >> 2) % IMEM_WORDS);

    always_comb begin
        // Take everything the buffer has room for, up to N
        if (fetch_enable && !fetch.restore) begin
            send = (fetch.spots > cnt_w'(N)) ? cnt_w'(N) : fetch.spots;
        end else begin
            send = '0;
        end
        fetch.count = send;

        for (int i = 0; i < N; i++) begin
            if (i < send) begin
                fetch.packets[i].pc   = (pc + xlen'(4 * i)) % mem_bytes;
                fetch.packets[i].inst = rdata[i];
            end else begin
                fetch.packets[i] = '0;  // Unused slots stay quiet
            end
        end
    end

    always_comb begin
        if (fetch.restore) begin
            next_pc = restore_pc;  // Redirect from the branch stack
        end else begin
            next_pc = (pc + (xlen'(send) << 2)) % mem_bytes;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;  // Programs start at address 0
        end else begin
            pc <= next_pc;
        end
    end

endmodule

// ==== design/frontend_pkg.sv ====
package frontend_pkg;

    // Instruction and PC width
    localparam int xlen = 32;

    // Defaults for the top-level parameters
    localparam int default_n          = 2;   // Superscalar width
    localparam int default_fb_sz      = 8;   // Instruction buffer depth
    localparam int default_imem_words = 64;  // Instruction memory depth in words

    // One fetched instruction tagged with its address
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetch_packet_t;

    // Steering class handed to dispatch
    typedef enum logic [2:0] {
        op_alu,
        op_load,
        op_store,
        op_branch,
        op_jump,
        op_other
    } op_class_t;

    // RISC-V major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_auipc  = 7'b0010111,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jalr   = 7'b1100111,
        opc_jal    = 7'b1101111
    } opcode_t;

endpackage

// ==== design/frontend_top.sv ====
`timescale 1ns/100ps

module frontend_top #(
    parameter int N          = frontend_pkg::default_n,
    parameter int FB_SZ      = frontend_pkg::default_fb_sz,
    parameter int IMEM_WORDS = frontend_pkg::default_imem_words
) (
    input  logic                                clock,
    input  logic                                rst,

    // Program load
    input  logic                                imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0]       imem_waddr,
    input  logic [frontend_pkg::xlen-1:0]       imem_wdata,

    input  logic                                fetch_enable,

    // From the branch stack
    input  logic                                restore_valid,
    input  logic [frontend_pkg::xlen-1:0]       restore_pc,

    // Dispatch side
    input  logic [$clog2(N+1)-1:0]              num_dispatched,
    output frontend_pkg::fetch_packet_t [N-1:0] outputs,
    output logic [$clog2(N+1)-1:0]              outputs_valid,
    output frontend_pkg::op_class_t     [N-1:0] op_class
);
    import frontend_pkg::*;

    logic [$clog2(IMEM_WORDS)-1:0] imem_raddr;
    logic [N-1:0][xlen-1:0]        imem_rdata;

    fetch_if #(.N(N)) fetch_bus ();

    assign fetch_bus.restore = restore_valid;

    inst_mem #(.N(N), .IMEM_WORDS(IMEM_WORDS)) u_inst_mem (
        .clock (clock),
        .we    (imem_we),
        .waddr (imem_waddr),
        .wdata (imem_wdata),
        .raddr (imem_raddr),
        .rdata (imem_rdata)
    );

    fetch_unit #(.N(N), .IMEM_WORDS(IMEM_WORDS)) u_fetch_unit (
        .clock        (clock),
        .rst          (rst),
        .fetch_enable (fetch_enable),
        .restore_pc   (restore_pc),
        .fetch        (fetch_bus.fetch_side),
        .raddr        (imem_raddr),
        .rdata        (imem_rdata)
    );

    inst_buffer #(.N(N), .FB_SZ(FB_SZ)) u_inst_buffer (
        .clock          (clock),
        .rst            (rst),
        .fetch          (fetch_bus.buffer_side),
        .num_dispatched (num_dispatched),
        .outputs        (outputs),
        .outputs_valid  (outputs_valid)
    );

    predecode #(.N(N)) u_predecode (
        .outputs       (outputs),
        .outputs_valid (outputs_valid),
        .op_class      (op_class)
    );

endmodule

// ==== design/inst_buffer.sv ====
`timescale 1ns/100ps

module inst_buffer #(
    parameter int N     = frontend_pkg::default_n,
    parameter int FB_SZ = frontend_pkg::default_fb_sz
) (
    input  logic                                clock,
    input  logic                                rst,
    fetch_if.buffer_side                        fetch,
    input  logic [$clog2(N+1)-1:0]              num_dispatched,  // At most outputs_valid
    output frontend_pkg::fetch_packet_t [N-1:0] outputs,
    output logic [$clog2(N+1)-1:0]              outputs_valid
);
    import frontend_pkg::*;

    localparam int cnt_w = $clog2(N + 1);
    localparam int ptr_w = (FB_SZ > 1) ? $clog2(FB_SZ) : 1;
    localparam int ent_w = $clog2(FB_SZ + 1);

    fetch_packet_t buffer [FB_SZ];

    logic [ptr_w-1:0] head;        // Oldest entry
    logic [ptr_w-1:0] next_head;
    logic [ptr_w-1:0] tail;        // Next free entry
    logic [ptr_w-1:0] next_tail;
    logic [ent_w-1:0] entries;
    logic [ent_w-1:0] next_entries;
    logic [ent_w-1:0] free_slots;

    always_comb begin
        next_head    = ptr_w'((int'(head) + int'(num_dispatched)) % FB_SZ);
        next_tail    = ptr_w'((int'(tail) + int'(fetch.count)) % FB_SZ);
        next_entries = entries + ent_w'(fetch.count) - ent_w'(num_dispatched);
        free_slots   = ent_w'(FB_SZ) - entries;
    end

    // Both counts are capped at N
    assign fetch.spots   = (free_slots < ent_w'(N)) ? cnt_w'(free_slots) : cnt_w'(N);
    assign outputs_valid = (entries < ent_w'(N)) ? cnt_w'(entries) : cnt_w'(N);

    // Present the oldest packets, zero in unused slots
    always_comb begin
        for (int i = 0; i < N; i++) begin
            if (i < outputs_valid) begin
                outputs[i] = buffer[(int'(head) + i) % FB_SZ];
            end else begin
                outputs[i] = '0;
            end
        end
    end

    // Payload storage
    always_ff @(posedge clock) begin
        for (int i = 0; i < N; i++) begin
            if (i < fetch.count) begin
                buffer[(int'(tail) + i) % FB_SZ] <= fetch.packets[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst || fetch.restore) begin
            head    <= '0;  // A restore flushes everything
            tail    <= '0;
            entries <= '0;
        end else begin
            head    <= next_head;
            tail    <= next_tail;
            entries <= next_entries;
        end
    end

endmodule

// ==== design/inst_mem.sv ====
`timescale 1ns/100ps

module inst_mem #(
    parameter int N          = frontend_pkg::default_n,
    parameter int IMEM_WORDS = frontend_pkg::default_imem_words
) (
    input  logic                                 clock,
    input  logic                                 we,
    input  logic [$clog2(IMEM_WORDS)-1:0]        waddr,
    input  logic [frontend_pkg::xlen-1:0]        wdata,
    input  logic [$clog2(IMEM_WORDS)-1:0]        raddr,  // Word index of read port 0
    output logic [N-1:0][frontend_pkg::xlen-1:0] rdata
);
    import frontend_pkg::*;

    logic [xlen-1:0] mem [IMEM_WORDS];

    // Load port used to place a program before fetch starts
    always_ff @(posedge clock) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // N consecutive words, wrapping at the end of memory
    always_comb begin
        for (int i = 0; i < N; i++) begin
            rdata[i] = mem[(int'(raddr) + i) % IMEM_WORDS];
        end
    end

endmodule

// ==== design/predecode.sv ====
`timescale 1ns/100ps

module predecode #(
    parameter int N = frontend_pkg::default_n
) (
    input  frontend_pkg::fetch_packet_t [N-1:0] outputs,
    input  logic [$clog2(N+1)-1:0]              outputs_valid,
    output frontend_pkg::op_class_t     [N-1:0] op_class
);
    import frontend_pkg::*;

    opcode_t opcode [N];

    always_comb begin
        for (int i = 0; i < N; i++) begin
            opcode[i] = opcode_t'(outputs[i].inst[6:0]);
            op_class[i] = op_other;  // Also covers empty slots
            if (i < outputs_valid) begin
                case (opcode[i])
                    opc_op,
                    opc_op_imm,
                    opc_lui,
                    opc_auipc:  op_class[i] = op_alu;
                    opc_load:   op_class[i] = op_load;
                    opc_store:  op_class[i] = op_store;
                    opc_branch: op_class[i] = op_branch;
                    opc_jal,
                    opc_jalr:   op_class[i] = op_jump;
                    default:    op_class[i] = op_other;  // System, fence, atomics and unknown
                endcase
            end
        end
    end

endmodule

// ==== project.f ====
design/frontend_pkg.sv
design/fetch_if.sv
design/inst_mem.sv
design/fetch_unit.sv
design/inst_buffer.sv
design/predecode.sv
design/frontend_top.sv
tb/frontend_tb.sv

// ==== tb/frontend_tb.sv ====
`timescale 1ns/100ps

module frontend_tb;
    import frontend_pkg::*;

    localparam int N          = 2;
    localparam int FB_SZ      = 8;
    localparam int IMEM_WORDS = 64;
    localparam int cnt_w      = $clog2(N + 1);
    localparam int addr_w     = $clog2(IMEM_WORDS);
    localparam int period     = 40;
    localparam int drive_dly  = 2;   // Inputs change this long after the rising edge
    localparam int wait_limit = 50;  // Cycles allowed for any single wait

    logic                   clock;
    logic                   rst;
    logic                   imem_we;
    logic [addr_w-1:0]      imem_waddr;
    logic [xlen-1:0]        imem_wdata;
    logic                   fetch_enable;
    logic                   restore_valid;
    logic [xlen-1:0]        restore_pc;
    logic [cnt_w-1:0]       num_dispatched;
    fetch_packet_t [N-1:0]  outputs;
    logic [cnt_w-1:0]       outputs_valid;
    op_class_t     [N-1:0]  op_class;

    logic [xlen-1:0] mem_copy [IMEM_WORDS];  // Program as loaded
    logic [xlen-1:0] exp_pc;                 // Next PC dispatch should see
    integer          seed;
    int              model_entries;          // Fetched and not yet dispatched
    int              dispatched;
    int              restores;

    frontend_top #(.N(N), .FB_SZ(FB_SZ), .IMEM_WORDS(IMEM_WORDS)) DUT (
        .clock          (clock),
        .rst            (rst),
        .imem_we        (imem_we),
        .imem_waddr     (imem_waddr),
        .imem_wdata     (imem_wdata),
        .fetch_enable   (fetch_enable),
        .restore_valid  (restore_valid),
        .restore_pc     (restore_pc),
        .num_dispatched (num_dispatched),
        .outputs        (outputs),
        .outputs_valid  (outputs_valid),
        .op_class       (op_class)
    );

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    function automatic int min_int(input int a, input int b);
        return (a < b) ? a : b;
    endfunction

    // Reference opcode rule, bits [6:0]
    function automatic op_class_t model_class(input logic [xlen-1:0] inst);
        case (inst[6:0])
            7'h33, 7'h13, 7'h37, 7'h17: return op_alu;
            7'h03:                      return op_load;
            7'h23:                      return op_store;
            7'h63:                      return op_branch;
            7'h6f, 7'h67:               return op_jump;
            default:                    return op_other;
        endcase
    endfunction

    // Classified opcodes plus a few that land in op_other
    function automatic logic [6:0] opcode_for(input int k, input logic [6:0] raw);
        case (k)
            0:       return 7'h33;  // OP
            1:       return 7'h13;  // OP-IMM
            2:       return 7'h37;  // LUI
            3:       return 7'h17;  // AUIPC
            4:       return 7'h03;  // LOAD
            5:       return 7'h23;  // STORE
            6:       return 7'h63;  // BRANCH
            7:       return 7'h6f;  // JAL
            8:       return 7'h67;  // JALR
            9:       return 7'h73;  // SYSTEM
            10:      return 7'h0f;  // MISC-MEM
            default: return raw;
        endcase
    endfunction

    task automatic fail_now(input string msg);
        $display("FAIL at %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic give_up(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "Run stopped before the end");
    endtask

    task automatic check_packet(input fetch_packet_t got, input fetch_packet_t exp,
                                input string what);
        if (got !== exp) begin
            fail_now($sformatf("%s: pc %h inst %h, expected pc %h inst %h",
                               what, got.pc, got.inst, exp.pc, exp.inst));
        end
    endtask

    task automatic check_class(input op_class_t got, input op_class_t exp, input string what);
        if (got !== exp) begin
            fail_now($sformatf("%s: class %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_count(input logic [cnt_w-1:0] got, input logic [cnt_w-1:0] exp,
                               input string what);
        if (got !== exp) begin
            fail_now($sformatf("%s: %0d, expected %0d", what, got, exp));
        end
    endtask

    // One cycle of dispatch and branch stack activity, then step to the next edge
    task automatic run_cycle(input bit allow_dispatch, input bit allow_restore);
        int              nd;
        int              shown;
        int              sent;
        bit              do_restore;
        logic [xlen-1:0] rpc;
        logic [xlen-1:0] slot_pc;
        fetch_packet_t   exp;
        nd    = 0;
        rpc   = '0;
        shown = min_int(N, model_entries);
        check_count(outputs_valid, cnt_w'(shown), "outputs_valid");
        // Presented slots continue the program in order, the rest are empty
        for (int i = 0; i < N; i++) begin
            if (i < shown) begin
                slot_pc  = (exp_pc + xlen'(4 * i)) % (IMEM_WORDS * 4);
                exp.pc   = slot_pc;
                exp.inst = mem_copy[slot_pc[addr_w+1:2]];
                check_packet(outputs[i], exp, "presented packet");
                check_class(op_class[i], model_class(exp.inst), "op_class");
            end else begin
                check_packet(outputs[i], '0, "empty slot");
                check_class(op_class[i], op_other, "op_class of an empty slot");
            end
        end
        do_restore = allow_restore && ({$random(seed)} % 16 == 0);
        if (allow_dispatch && !do_restore) begin
            nd = {$random(seed)} % (shown + 1);
        end
        // Dispatch retires the oldest nd packets
        exp_pc = (exp_pc + xlen'(4 * nd)) % (IMEM_WORDS * 4);
        if (do_restore) begin
            rpc           = xlen'(({$random(seed)} % IMEM_WORDS) * 4);
            exp_pc        = rpc;
            model_entries = 0;  // Buffer flushed at this edge
            restores++;
        end else begin
            sent          = fetch_enable ? min_int(N, FB_SZ - model_entries) : 0;
            model_entries = model_entries + sent - nd;
        end
        dispatched     += nd;
        num_dispatched = cnt_w'(nd);
        restore_valid  = do_restore;
        restore_pc     = rpc;
        @(posedge clock);
        #drive_dly;
    endtask

    task automatic wait_until_full(input string what);
        int waited;
        waited = 0;
        while (outputs_valid !== cnt_w'(N)) begin
            if (waited == wait_limit) begin
                give_up($sformatf("Timeout: outputs_valid never reached %0d while waiting for %s",
                                  N, what));
            end
            run_cycle(1'b0, 1'b0);
            waited++;
        end
    endtask

    initial begin
        logic [xlen-1:0] word;
        fetch_packet_t   exp;
        seed           = 32'h50ad_efce;
        dispatched     = 0;
        restores       = 0;
        model_entries  = 0;
        exp_pc         = '0;
        rst            = 1'b1;
        imem_we        = 1'b0;
        imem_waddr     = '0;
        imem_wdata     = '0;
        fetch_enable   = 1'b0;
        restore_valid  = 1'b0;
        restore_pc     = '0;
        num_dispatched = '0;
        repeat (3) @(posedge clock);
        #drive_dly;
        rst = 1'b0;
        check_count(outputs_valid, '0, "outputs_valid after reset");

        // Program load while fetch is stopped
        for (int w = 0; w < IMEM_WORDS; w++) begin
            word       = $random(seed);
            word[6:0]  = opcode_for(int'({$random(seed)} % 13), word[6:0]);
            mem_copy[w] = word;
            imem_we    = 1'b1;
            imem_waddr = addr_w'(w);
            imem_wdata = word;
            @(posedge clock);
            #drive_dly;
            check_count(outputs_valid, '0, "outputs_valid while loading");
        end
        imem_we      = 1'b0;
        fetch_enable = 1'b1;

        wait_until_full("the first packets");
        for (int i = 0; i < N; i++) begin
            exp.pc   = xlen'(4 * i);
            exp.inst = mem_copy[i];
            check_packet(outputs[i], exp, "first packet");
        end

        repeat (400) run_cycle(1'b1, 1'b1);

        // Dispatch stalled, the buffer fills and fetch holds
        wait_until_full("back-pressure");
        for (int c = 0; c < 2 * FB_SZ; c++) begin
            run_cycle(1'b0, 1'b0);
            check_count(outputs_valid, cnt_w'(N), "outputs_valid under back-pressure");
        end

        repeat (100) run_cycle(1'b1, 1'b0);
        repeat (300) run_cycle(1'b1, 1'b1);

        if (restores == 0 || dispatched < 200) begin
            give_up($sformatf("Too little activity: only %0d restores and %0d dispatched packets",
                              restores, dispatched));
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule
